// ==== Makefile ====
# Verilator build for the RV32IM decode pipeline testbench

TOOL      := verilator
FLAGS     := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
TOP       := tb_decode_pipe
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not the simulator exit code
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/exec_ctrl_stage.sv ====
`timescale 1ns/1ps

module exec_ctrl_stage import rv32_decode_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n_i,
  input  logic       field_valid_i,
  input  opcode_t    opcode_i,
  input  funct3_t    funct3_i,
  input  funct7_t    funct7_i,
  input  reg_idx_t   rd_i,
  input  reg_idx_t   rs1_i,
  input  reg_idx_t   rs2_i,
  input  word_t      imm_i,
  input  logic       csr_rw_valid_i,
  output logic       ctrl_valid_o,
  output reg_idx_t   rd_o,
  output reg_idx_t   rs1_o,
  output reg_idx_t   rs2_o,
  output word_t      imm_o,
  output logic       wen_o,
  output w_src_t     w_src_o,
  output src_a_sel_t src_a_sel_o,
  output src_b_sel_t src_b_sel_o,
  output alu_op_t    alu_op_o,
  output sfu_t       sfu_o,
  output sign_t      sign_o,
  output logic       mul_high_o,
  output logic       div_quot_o,
  output logic       dren_o,
  output logic       dwen_o,
  output logic       branch_o,
  output funct3_t    branch_type_o,
  output logic       jump_o,
  output logic       j_sel_o,
  output logic       illegal_o
);

  logic       wen_d;
  w_src_t     w_src_d;
  src_a_sel_t src_a_d;
  src_b_sel_t src_b_d;
  alu_op_t    alu_op_d;
  sfu_t       sfu_d;
  sign_t      sign_d;
  logic       illegal_d;
  logic       is_imm;
  logic       is_rr;
  logic       alt;

  // funct7 bit 5 is instruction bit 30
  assign alt    = funct7_i[ALT_FUNCT7_BIT-25];
  assign is_imm = (opcode_i == IMMED);
  assign is_rr  = (opcode_i == REGREG);

  always_comb begin
    case (opcode_i)
      IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD : wen_d = 1'b1;
      // csr ops write rd, priv ops do not
      SYSTEM  : wen_d = csr_rw_valid_i;
      default : wen_d = 1'b0;
    endcase
    case (opcode_i)
      LOAD                 : w_src_d = LOAD_SRC;
      JAL, JALR            : w_src_d = JUMP_SRC;
      LUI                  : w_src_d = LUI_SRC;
      IMMED, AUIPC, REGREG : w_src_d = ALU_SRC;
      SYSTEM               : w_src_d = CSR_SRC;
      default              : w_src_d = LOAD_SRC;
    endcase
    // a: 0 rs1, 1 store path, 2 pc
    case (opcode_i)
      REGREG, IMMED, LOAD, BRANCH, JALR, SYSTEM : src_a_d = 2'd0;
      STORE   : src_a_d = 2'd1;
      default : src_a_d = 2'd2;
    endcase
    // b: 0 store imm, 1 rs2, 2 imm, 3 upper imm
    case (opcode_i)
      STORE       : src_b_d = 2'd0;
      IMMED, LOAD : src_b_d = 2'd2;
      AUIPC       : src_b_d = 2'd3;
      default     : src_b_d = 2'd1;
    endcase
  end

  // alu op, first match wins
  always_comb begin
    if ((is_imm || is_rr) && funct3_i == F3_SLL)
      alu_op_d = ALU_SLL;
    else if ((is_imm || is_rr) && funct3_i == F3_SR)
      alu_op_d = alt ? ALU_SRA : ALU_SRL;
    else if (is_rr && funct3_i == F3_ADDSUB)
      alu_op_d = alt ? ALU_SUB : ALU_ADD;
    else if ((is_imm || is_rr) && funct3_i == F3_AND)
      alu_op_d = ALU_AND;
    else if ((is_imm || is_rr) && funct3_i == F3_OR)
      alu_op_d = ALU_OR;
    else if ((is_imm || is_rr) && funct3_i == F3_XOR)
      alu_op_d = ALU_XOR;
    else if ((is_imm || is_rr) && funct3_i == F3_SLT)
      alu_op_d = ALU_SLT;
    else if ((is_imm || is_rr) && funct3_i == F3_SLTU)
      alu_op_d = ALU_SLTU;
    else
      // addi, load, store, auipc and the rest
      alu_op_d = ALU_ADD;
  end

  always_comb begin
    if (is_rr && funct7_i == MULDIV_FUNCT7)
      sfu_d = funct3_i[2] ? DIV_S : MUL_S;
    else if (opcode_i == LOAD || opcode_i == STORE)
      sfu_d = LOADSTORE_S;
    else
      sfu_d = ARITH_S;
    // mulhsu is the only mixed case
    case (funct3_i)
      3'b011, 3'b101, 3'b111 : sign_d = UNSIGNED;
      3'b010                 : sign_d = SIGNED_UNSIGNED;
      default                : sign_d = SIGNED;
    endcase
  end

  always_comb begin
    case (opcode_i)
      // funct7 bit 0 only legal as the M group
      REGREG : illegal_d = funct7_i[0] && (funct7_i != MULDIV_FUNCT7);
      LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
      IMMED, SYSTEM, MISCMEM, ZERO : illegal_d = 1'b0;
      default : illegal_d = 1'b1;
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ctrl_valid_o  <= 1'b0;
      rd_o          <= '0;
      rs1_o         <= '0;
      rs2_o         <= '0;
      imm_o         <= '0;
      wen_o         <= 1'b0;
      w_src_o       <= LOAD_SRC;
      src_a_sel_o   <= '0;
      src_b_sel_o   <= '0;
      alu_op_o      <= ALU_ADD;
      sfu_o         <= ARITH_S;
      sign_o        <= SIGNED;
      mul_high_o    <= 1'b0;
      div_quot_o    <= 1'b0;
      dren_o        <= 1'b0;
      dwen_o        <= 1'b0;
      branch_o      <= 1'b0;
      branch_type_o <= '0;
      jump_o        <= 1'b0;
      j_sel_o       <= 1'b0;
      illegal_o     <= 1'b0;
    end else begin
      ctrl_valid_o  <= field_valid_i;
      rd_o          <= rd_i;
      rs1_o         <= rs1_i;
      rs2_o         <= rs2_i;
      imm_o         <= imm_i;
      wen_o         <= wen_d;
      w_src_o       <= w_src_d;
      src_a_sel_o   <= src_a_d;
      src_b_sel_o   <= src_b_d;
      alu_op_o      <= alu_op_d;
      sfu_o         <= sfu_d;
      sign_o        <= sign_d;
      // mulh/mulhsu/mulhu take the upper word
      mul_high_o    <= |funct3_i[1:0];
      // div/divu versus rem/remu
      div_quot_o    <= (sfu_d == DIV_S) && !funct3_i[1];
      dren_o        <= (opcode_i == LOAD);
      dwen_o        <= (opcode_i == STORE);
      branch_o      <= (opcode_i == BRANCH);
      branch_type_o <= funct3_i;
      jump_o        <= (opcode_i == JAL) || (opcode_i == JALR);
      // pc-relative target only for jal
      j_sel_o       <= (opcode_i == JAL);
      illegal_o     <= illegal_d;
    end
  end

endmodule

// ==== hw/instr_field_stage.sv ====
`timescale 1ns/1ps

module instr_field_stage import rv32_decode_pkg::*; (
  input  logic     CLK,
  input  logic     arst_n_i,
  input  logic     instr_valid_i,
  input  word_t    instr_i,
  output logic     field_valid_o,
  output opcode_t  opcode_o,
  output funct3_t  funct3_o,
  output funct7_t  funct7_o,
  output reg_idx_t rd_o,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  output word_t    imm_o
);

  logic  valid_q;
  word_t instr_q;

  // format immediates, sign taken from bit 31
  word_t imm_i_fmt;
  word_t imm_s_fmt;
  word_t imm_b_fmt;
  word_t imm_j_fmt;
  word_t imm_u_fmt;

  // instruction register, loaded every edge
  always_ff @(posedge CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else begin
      valid_q <= instr_valid_i;
      instr_q <= instr_i;
    end
  end

  assign field_valid_o = valid_q;

  // fixed field positions
  assign opcode_o = opcode_t'(instr_q[6:0]);
  assign rd_o     = instr_q[11:7];
  assign funct3_o = instr_q[14:12];
  assign rs1_o    = instr_q[19:15];
  assign rs2_o    = instr_q[24:20];
  assign funct7_o = instr_q[31:25];

  assign imm_i_fmt = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s_fmt = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  // branch offset, bit 0 always zero
  assign imm_b_fmt = {{19{instr_q[31]}}, instr_q[31], instr_q[7],
                      instr_q[30:25], instr_q[11:8], 1'b0};
  // jal offset, scrambled across the upper bits
  assign imm_j_fmt = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12],
                      instr_q[20], instr_q[30:21], 1'b0};
  assign imm_u_fmt = {instr_q[31:12], 12'b0};

  // one immediate per format
  // shift-immediates keep the I form, shamt sits in imm[4:0]
  always_comb begin
    case (opcode_o)
      IMMED, LOAD, JALR, SYSTEM : imm_o = imm_i_fmt;
      STORE                     : imm_o = imm_s_fmt;
      BRANCH                    : imm_o = imm_b_fmt;
      JAL                       : imm_o = imm_j_fmt;
      LUI, AUIPC                : imm_o = imm_u_fmt;
      default                   : imm_o = '0;
    endcase
  end

endmodule

// ==== hw/rv32_decode_pipe.sv ====
`timescale 1ns/1ps

module rv32_decode_pipe import rv32_decode_pkg::*; (
  input  logic       CLK,
  input  logic       arst_n_i,
  input  logic       instr_valid_i,
  input  word_t      instr_i,
  // exec controls
  output logic       ctrl_valid_o,
  output reg_idx_t   rd_o,
  output reg_idx_t   rs1_o,
  output reg_idx_t   rs2_o,
  output word_t      imm_o,
  output logic       wen_o,
  output w_src_t     w_src_o,
  output src_a_sel_t src_a_sel_o,
  output src_b_sel_t src_b_sel_o,
  output alu_op_t    alu_op_o,
  output sfu_t       sfu_o,
  output sign_t      sign_o,
  output logic       mul_high_o,
  output logic       div_quot_o,
  output logic       dren_o,
  output logic       dwen_o,
  output logic       branch_o,
  output funct3_t    branch_type_o,
  output logic       jump_o,
  output logic       j_sel_o,
  output logic       illegal_o,
  // system controls
  output logic       mret_o,
  output logic       ecall_o,
  output logic       ebreak_o,
  output logic       wfi_o,
  output logic       csr_swap_o,
  output logic       csr_set_o,
  output logic       csr_clr_o,
  output logic       csr_imm_o,
  output logic       csr_instr_o,
  output csr_addr_t  csr_addr_o,
  output word_t      csr_zimm_o,
  output logic       ifence_o
);

  // stage 1 to stage 2
  logic     f_valid;
  opcode_t  f_opcode;
  funct3_t  f_funct3;
  funct7_t  f_funct7;
  reg_idx_t f_rd;
  reg_idx_t f_rs1;
  reg_idx_t f_rs2;
  word_t    f_imm;
  // sys decode into exec write enable
  logic     csr_rw_valid;

  instr_field_stage u_field (
    .CLK           (CLK),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .field_valid_o (f_valid),
    .opcode_o      (f_opcode),
    .funct3_o      (f_funct3),
    .funct7_o      (f_funct7),
    .rd_o          (f_rd),
    .rs1_o         (f_rs1),
    .rs2_o         (f_rs2),
    .imm_o         (f_imm)
  );

  exec_ctrl_stage u_exec (
    .CLK            (CLK),
    .arst_n_i       (arst_n_i),
    .field_valid_i  (f_valid),
    .opcode_i       (f_opcode),
    .funct3_i       (f_funct3),
    .funct7_i       (f_funct7),
    .rd_i           (f_rd),
    .rs1_i          (f_rs1),
    .rs2_i          (f_rs2),
    .imm_i          (f_imm),
    .csr_rw_valid_i (csr_rw_valid),
    .ctrl_valid_o   (ctrl_valid_o),
    .rd_o           (rd_o),
    .rs1_o          (rs1_o),
    .rs2_o          (rs2_o),
    .imm_o          (imm_o),
    .wen_o          (wen_o),
    .w_src_o        (w_src_o),
    .src_a_sel_o    (src_a_sel_o),
    .src_b_sel_o    (src_b_sel_o),
    .alu_op_o       (alu_op_o),
    .sfu_o          (sfu_o),
    .sign_o         (sign_o),
    .mul_high_o     (mul_high_o),
    .div_quot_o     (div_quot_o),
    .dren_o         (dren_o),
    .dwen_o         (dwen_o),
    .branch_o       (branch_o),
    .branch_type_o  (branch_type_o),
    .jump_o         (jump_o),
    .j_sel_o        (j_sel_o),
    .illegal_o      (illegal_o)
  );

  sys_ctrl_stage u_sys (
    .CLK            (CLK),
    .arst_n_i       (arst_n_i),
    .opcode_i       (f_opcode),
    .funct3_i       (f_funct3),
    .rs1_i          (f_rs1),
    .imm_i          (f_imm),
    .csr_rw_valid_o (csr_rw_valid),
    .mret_o         (mret_o),
    .ecall_o        (ecall_o),
    .ebreak_o       (ebreak_o),
    .wfi_o          (wfi_o),
    .csr_swap_o     (csr_swap_o),
    .csr_set_o      (csr_set_o),
    .csr_clr_o      (csr_clr_o),
    .csr_imm_o      (csr_imm_o),
    .csr_instr_o    (csr_instr_o),
    .csr_addr_o     (csr_addr_o),
    .csr_zimm_o     (csr_zimm_o),
    .ifence_o       (ifence_o)
  );

endmodule

// ==== hw/rv32_decode_pkg.sv ====
package rv32_decode_pkg;

  // datapath and register file widths
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  // funct7 of the M extension reg-reg group
  localparam logic [6:0] MULDIV_FUNCT7 = 7'b000_0001;
  // instruction bit picking sub over add and sra over srl
  localparam int ALT_FUNCT7_BIT = 30;

  // privileged codes, held in the I-immediate field
  localparam logic [11:0] PRIV_ECALL  = 12'h000;
  localparam logic [11:0] PRIV_EBREAK = 12'h001;
  localparam logic [11:0] PRIV_WFI    = 12'h105;
  localparam logic [11:0] PRIV_MRET   = 12'h302;

  // arithmetic funct3, shared by reg-reg and reg-imm forms
  localparam logic [2:0] F3_ADDSUB = 3'b000;
  localparam logic [2:0] F3_SLL    = 3'b001;
  localparam logic [2:0] F3_SLT    = 3'b010;
  localparam logic [2:0] F3_SLTU   = 3'b011;
  localparam logic [2:0] F3_XOR    = 3'b100;
  localparam logic [2:0] F3_SR     = 3'b101;
  localparam logic [2:0] F3_OR     = 3'b110;
  localparam logic [2:0] F3_AND    = 3'b111;

  // SYSTEM funct3
  localparam logic [2:0] F3_PRIV   = 3'b000;
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // MISC-MEM funct3
  localparam logic [2:0] F3_FENCEI = 3'b001;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0]           funct3_t;
  typedef logic [6:0]           funct7_t;
  typedef logic [11:0]          csr_addr_t;

  // base opcodes, all-zero word decodes as legal
  typedef enum logic [6:0] {
    ZERO    = 7'b000_0000,
    LOAD    = 7'b000_0011,
    MISCMEM = 7'b000_1111,
    IMMED   = 7'b001_0011,
    AUIPC   = 7'b001_0111,
    STORE   = 7'b010_0011,
    REGREG  = 7'b011_0011,
    LUI     = 7'b011_0111,
    BRANCH  = 7'b110_0011,
    JALR    = 7'b110_0111,
    JAL     = 7'b110_1111,
    SYSTEM  = 7'b111_0011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } alu_op_t;

  // write-back mux source
  typedef enum logic [2:0] {LOAD_SRC, JUMP_SRC, LUI_SRC, ALU_SRC, CSR_SRC} w_src_t;

  // functional unit class
  typedef enum logic [1:0] {ARITH_S, MUL_S, DIV_S, LOADSTORE_S} sfu_t;

  typedef enum logic [1:0] {SIGNED, UNSIGNED, SIGNED_UNSIGNED} sign_t;

  // operand mux selects
  typedef logic [1:0] src_a_sel_t;
  typedef logic [1:0] src_b_sel_t;

endpackage

// ==== hw/sys_ctrl_stage.sv ====
`timescale 1ns/1ps

module sys_ctrl_stage import rv32_decode_pkg::*; (
  input  logic      CLK,
  input  logic      arst_n_i,
  input  opcode_t   opcode_i,
  input  funct3_t   funct3_i,
  input  reg_idx_t  rs1_i,
  input  word_t     imm_i,
  output logic      csr_rw_valid_o,
  output logic      mret_o,
  output logic      ecall_o,
  output logic      ebreak_o,
  output logic      wfi_o,
  output logic      csr_swap_o,
  output logic      csr_set_o,
  output logic      csr_clr_o,
  output logic      csr_imm_o,
  output logic      csr_instr_o,
  output csr_addr_t csr_addr_o,
  output word_t     csr_zimm_o,
  output logic      ifence_o
);

  logic      is_sys;
  logic      is_priv;
  csr_addr_t imm12;
  logic      swap_d;
  logic      set_d;
  logic      clr_d;
  logic      imm_form_d;

  assign is_sys  = (opcode_i == SYSTEM);
  assign is_priv = is_sys && (funct3_i == F3_PRIV);
  // raw I field, priv code or csr number
  assign imm12   = imm_i[11:0];

  // csr op kind, immediate forms mirror the rs1 forms
  assign swap_d     = is_sys && (funct3_i == F3_CSRRW || funct3_i == F3_CSRRWI);
  assign set_d      = is_sys && (funct3_i == F3_CSRRS || funct3_i == F3_CSRRSI);
  assign clr_d      = is_sys && (funct3_i == F3_CSRRC || funct3_i == F3_CSRRCI);
  assign imm_form_d = is_sys && (funct3_i == F3_CSRRWI || funct3_i == F3_CSRRSI ||
                                 funct3_i == F3_CSRRCI);

  // feeds the exec stage write enable in the same cycle
  assign csr_rw_valid_o = swap_d | set_d | clr_d;

  always_ff @(posedge CLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mret_o      <= 1'b0;
      ecall_o     <= 1'b0;
      ebreak_o    <= 1'b0;
      wfi_o       <= 1'b0;
      csr_swap_o  <= 1'b0;
      csr_set_o   <= 1'b0;
      csr_clr_o   <= 1'b0;
      csr_imm_o   <= 1'b0;
      csr_instr_o <= 1'b0;
      csr_addr_o  <= '0;
      csr_zimm_o  <= '0;
      ifence_o    <= 1'b0;
    end else begin
      mret_o      <= is_priv && (imm12 == PRIV_MRET);
      ecall_o     <= is_priv && (imm12 == PRIV_ECALL);
      ebreak_o    <= is_priv && (imm12 == PRIV_EBREAK);
      wfi_o       <= is_priv && (imm12 == PRIV_WFI);
      csr_swap_o  <= swap_d;
      csr_set_o   <= set_d;
      csr_clr_o   <= clr_d;
      csr_imm_o   <= imm_form_d;
      csr_instr_o <= is_sys;
      csr_addr_o  <= imm12;
      // uimm5 lives in the rs1 slot
      csr_zimm_o  <= {{(XLEN-REG_IDX_W){1'b0}}, rs1_i};
      ifence_o    <= (opcode_i == MISCMEM) && (funct3_i == F3_FENCEI);
    end
  end

endmodule

// ==== test/decode_stimulus.txt ====
# test instr imm wen w_src alu_op sfu sign illegal flags (enums as numbers, rest hex)
# flag bits: 0 mret 1 ecall 2 ebreak 3 wfi 4 swap 5 set 6 clr 7 csr_imm 8 csr_instr
# 9 ifence 10 mul_high 11 div_quot 12 dren 13 dwen 14 branch 15 jump
1 FFF10093 FFFFFFFF 1 3 0 0 0 0 0000
1 41F35293 0000041F 1 3 4 0 1 0 0400
1 FE952E23 FFFFFFFC 0 0 0 3 2 0 2400
1 FE208CE3 FFFFFFF8 0 0 0 0 0 0 4000
1 FFDFF06F FFFFFFFC 1 1 0 0 1 0 8400
1 800002B7 80000000 1 2 0 0 0 0 0000
1 12345317 12345000 1 3 0 0 1 0 0400
1 80062583 FFFFF800 1 0 0 3 2 0 1400
2 003100B3 00000000 1 3 0 0 0 0 0000
2 403100B3 00000000 1 3 1 0 0 0 0000
2 003110B3 00000000 1 3 2 0 0 0 0400
2 003120B3 00000000 1 3 8 0 2 0 0400
2 003130B3 00000000 1 3 9 0 1 0 0400
2 003140B3 00000000 1 3 7 0 0 0 0000
2 003150B3 00000000 1 3 3 0 1 0 0400
2 403150B3 00000000 1 3 4 0 1 0 0400
2 003160B3 00000000 1 3 6 0 0 0 0400
2 003170B3 00000000 1 3 5 0 1 0 0400
2 00512093 00000005 1 3 8 0 2 0 0400
2 00713093 00000007 1 3 9 0 1 0 0400
2 FFF14093 FFFFFFFF 1 3 7 0 0 0 0000
2 0F016093 000000F0 1 3 6 0 0 0 0400
2 0FF17093 000000FF 1 3 5 0 1 0 0400
2 00311093 00000003 1 3 2 0 0 0 0400
2 00415093 00000004 1 3 3 0 1 0 0400
3 023100B3 00000000 1 3 0 1 0 0 0000
3 023110B3 00000000 1 3 2 1 0 0 0400
3 023120B3 00000000 1 3 8 1 2 0 0400
3 023130B3 00000000 1 3 9 1 1 0 0400
3 023140B3 00000000 1 3 7 2 0 0 0800
3 023150B3 00000000 1 3 3 2 1 0 0C00
3 023160B3 00000000 1 3 6 2 0 0 0400
3 023170B3 00000000 1 3 5 2 1 0 0400
4 00000073 00000000 0 4 0 0 0 0 0102
4 00100073 00000001 0 4 0 0 0 0 0104
4 10500073 00000105 0 4 0 0 0 0 0108
4 30200073 00000302 0 4 0 0 0 0 0101
4 340110F3 00000340 1 4 0 0 0 0 0510
4 300221F3 00000300 1 4 0 0 2 0 0520
4 304332F3 00000304 1 4 0 0 1 0 0540
4 FC0FD3F3 FFFFFFC0 1 4 0 0 1 0 0590
4 3412E473 00000341 1 4 0 0 0 0 05A0
4 3420F4F3 00000342 1 4 0 0 1 0 05C0
4 0000100F 00000000 0 0 0 0 0 0 0600
5 00000007 00000000 0 0 0 0 0 1 0000
5 063100B3 00000000 1 3 0 0 0 1 0000
5 00000000 00000000 0 0 0 0 0 0 0000

// ==== test/tb_decode_pipe.sv ====
`timescale 1ns/1ps

module tb_decode_pipe import rv32_decode_pkg::*; ();

  localparam int CLK_PERIOD = 40;

  // expected control word and the cycle its instruction entered
  typedef struct {
    int      test_no;
    word_t   instr;
    word_t   imm;
    logic    wen;
    w_src_t  w_src;
    alu_op_t alu_op;
    sfu_t    sfu;
    sign_t   sign;
    logic    illegal;
    logic [15:0] flags;
    int      entry;
  } expect_t;

  logic       CLK;
  logic       arst_n_i;
  logic       instr_valid_i;
  word_t      instr_i;
  logic       ctrl_valid_o;
  reg_idx_t   rd_o, rs1_o, rs2_o;
  word_t      imm_o;
  logic       wen_o;
  w_src_t     w_src_o;
  src_a_sel_t src_a_sel_o;
  src_b_sel_t src_b_sel_o;
  alu_op_t    alu_op_o;
  sfu_t       sfu_o;
  sign_t      sign_o;
  logic       mul_high_o, div_quot_o, dren_o, dwen_o, branch_o;
  funct3_t    branch_type_o;
  logic       jump_o, j_sel_o, illegal_o;
  logic       mret_o, ecall_o, ebreak_o, wfi_o;
  logic       csr_swap_o, csr_set_o, csr_clr_o, csr_imm_o, csr_instr_o;
  csr_addr_t  csr_addr_o;
  word_t      csr_zimm_o;
  logic       ifence_o;

  expect_t     stim_q[$];
  expect_t     pend_q[$];
  int          cycle;
  int          errors;
  int          checks;
  int          n_done;
  int          cur_test;
  int          test_base;
  int          test_cnt;
  logic [31:0] rng_state;
  bit          loaded;

  // bit order of the flag column in the stimulus file
  string flag_name [16] = '{"mret_o", "ecall_o", "ebreak_o", "wfi_o", "csr_swap_o",
    "csr_set_o", "csr_clr_o", "csr_imm_o", "csr_instr_o", "ifence_o", "mul_high_o",
    "div_quot_o", "dren_o", "dwen_o", "branch_o", "jump_o"};

  rv32_decode_pipe dut0 (.*);

  initial CLK = 1'b0;
  always #(CLK_PERIOD/2) CLK = ~CLK;

  always @(posedge CLK) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // strobes packed in the same order as flag_name
  function automatic logic [15:0] gather_flags();
    return {jump_o, branch_o, dwen_o, dren_o, div_quot_o, mul_high_o, ifence_o,
            csr_instr_o, csr_imm_o, csr_clr_o, csr_set_o, csr_swap_o,
            wfi_o, ebreak_o, ecall_o, mret_o};
  endfunction

  // operand a is rs1 (0), the store path (1) or the pc (2)
  function automatic src_a_sel_t operand_a_select(input opcode_t op);
    case (op)
      REGREG, IMMED, LOAD, BRANCH, JALR, SYSTEM : return 2'd0;
      STORE   : return 2'd1;
      default : return 2'd2;
    endcase
  endfunction

  // operand b is the store imm (0), rs2 (1), the imm (2) or the upper imm (3)
  function automatic src_b_sel_t operand_b_select(input opcode_t op);
    case (op)
      STORE       : return 2'd0;
      IMMED, LOAD : return 2'd2;
      AUIPC       : return 2'd3;
      default     : return 2'd1;
    endcase
  endfunction

  task automatic report_problem(input string msg);
    errors++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic record_mismatch(input string name, input string exp_s, input string act_s);
    errors++;
    $display("CHECK FAILED at %0t: %s expected %s got %s", $time, name, exp_s, act_s);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%08h", exp), $sformatf("%08h", act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_funct3(input string name, input funct3_t exp, input funct3_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_csr_addr(input string name, input csr_addr_t exp,
                                input csr_addr_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%03h", exp), $sformatf("%03h", act));
  endtask

  task automatic check_src_a_sel(input string name, input src_a_sel_t exp,
                                 input src_a_sel_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_src_b_sel(input string name, input src_b_sel_t exp,
                                 input src_b_sel_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  task automatic check_alu_op(input string name, input alu_op_t exp, input alu_op_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, exp.name(), $sformatf("%s (%0d)", act.name(), act));
  endtask

  task automatic check_w_src(input string name, input w_src_t exp, input w_src_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, exp.name(), $sformatf("%s (%0d)", act.name(), act));
  endtask

  task automatic check_sfu(input string name, input sfu_t exp, input sfu_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, exp.name(), $sformatf("%s (%0d)", act.name(), act));
  endtask

  task automatic check_sign(input string name, input sign_t exp, input sign_t act);
    checks++;
    if (act !== exp)
      record_mismatch(name, exp.name(), $sformatf("%s (%0d)", act.name(), act));
  endtask

  task automatic finish_test();
    $display("test %0d finished: %0d instructions, %0d errors",
             cur_test, test_cnt, errors - test_base);
    test_base = errors;
    test_cnt  = 0;
  endtask

  // comment lines fail the %d scan and are skipped
  task automatic load_stimulus();
    int          fd;
    int          n;
    string       line;
    int          tno, wen, wsrc, aop, sfu, sgn, ill;
    logic [31:0] ins, imm, flg;
    expect_t     e;
    fd = $fopen("test/decode_stimulus.txt", "r");
    if (fd == 0) begin
      report_problem("cannot open test/decode_stimulus.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%d %h %h %d %d %d %d %d %d %h",
                  tno, ins, imm, wen, wsrc, aop, sfu, sgn, ill, flg);
      if (n == 10) begin
        e.test_no = tno;
        e.instr   = ins;
        e.imm     = imm;
        e.wen     = wen[0];
        e.w_src   = w_src_t'(wsrc[2:0]);
        e.alu_op  = alu_op_t'(aop[3:0]);
        e.sfu     = sfu_t'(sfu[1:0]);
        e.sign    = sign_t'(sgn[1:0]);
        e.illegal = ill[0];
        e.flags   = flg[15:0];
        e.entry   = 0;
        stim_q.push_back(e);
      end else if (n > 0) begin
        report_problem($sformatf("malformed stimulus line: %s", line));
      end
    end
    $fclose(fd);
    if (stim_q.size() == 0)
      report_problem("no stimulus records read");
  endtask

  task automatic check_record(input expect_t e);
    logic [15:0] act_flags;
    opcode_t     op;
    int          i;
    if (e.test_no != cur_test) begin
      finish_test();
      cur_test = e.test_no;
    end
    test_cnt++;
    n_done++;
    op = opcode_t'(e.instr[6:0]);
    if (cycle - e.entry != 2)
      report_problem($sformatf("instruction %08h came out after %0d cycles instead of 2",
                               e.instr, cycle - e.entry));
    check_word("imm_o", e.imm, imm_o);
    check_bit("wen_o", e.wen, wen_o);
    check_w_src("w_src_o", e.w_src, w_src_o);
    check_alu_op("alu_op_o", e.alu_op, alu_op_o);
    check_sfu("sfu_o", e.sfu, sfu_o);
    check_sign("sign_o", e.sign, sign_o);
    check_bit("illegal_o", e.illegal, illegal_o);
    // register fields sit at fixed positions in every format
    check_reg_idx("rd_o", e.instr[11:7], rd_o);
    check_reg_idx("rs1_o", e.instr[19:15], rs1_o);
    check_reg_idx("rs2_o", e.instr[24:20], rs2_o);
    check_funct3("branch_type_o", e.instr[14:12], branch_type_o);
    check_src_a_sel("src_a_sel_o", operand_a_select(op), src_a_sel_o);
    check_src_b_sel("src_b_sel_o", operand_b_select(op), src_b_sel_o);
    // pc-relative target only for jal
    check_bit("j_sel_o", op == JAL, j_sel_o);
    // csr number from the low I-field
    check_csr_addr("csr_addr_o", e.imm[11:0], csr_addr_o);
    // uimm from the rs1 slot
    check_word("csr_zimm_o", {27'b0, e.instr[19:15]}, csr_zimm_o);
    act_flags = gather_flags();
    for (i = 0; i < 16; i++)
      check_bit(flag_name[i], e.flags[i], act_flags[i]);
  endtask

  // sample mid-cycle while the outputs are settled
  task automatic advance();
    @(negedge CLK);
    if (ctrl_valid_o === 1'b1) begin
      if (pend_q.size() == 0)
        report_problem("ctrl_valid_o high with no instruction in flight");
      else
        check_record(pend_q.pop_front());
    end else if (ctrl_valid_o !== 1'b0) begin
      report_problem("ctrl_valid_o is unknown");
    end else if (pend_q.size() > 0 && cycle - pend_q[0].entry >= 2) begin
      report_problem($sformatf("no output for instruction %08h", pend_q[0].instr));
      void'(pend_q.pop_front());
    end
  endtask

  initial begin
    expect_t     e;
    int          idx;
    int          gap;
    logic [15:0] rst_flags;
    int          i;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    cycle         = 0;
    errors        = 0;
    checks        = 0;
    n_done        = 0;
    cur_test      = 0;
    test_base     = 0;
    test_cnt      = 0;
    rng_state     = 32'd47;
    load_stimulus();
    loaded = 1'b1;

    // test 0 is the state held in reset
    repeat (2) @(negedge CLK);
    check_bit("ctrl_valid_o", 1'b0, ctrl_valid_o);
    check_bit("wen_o", 1'b0, wen_o);
    check_bit("illegal_o", 1'b0, illegal_o);
    rst_flags = gather_flags();
    for (i = 0; i < 16; i++)
      check_bit(flag_name[i], 1'b0, rst_flags[i]);
    arst_n_i = 1'b1;

    for (idx = 0; idx < stim_q.size(); idx++) begin
      rng_state = xorshift(rng_state);
      if (rng_state[1:0] == 2'b00)
        gap = rng_state[2] ? 2 : 1;
      else
        gap = 0;
      // idle cycles carry junk that must not surface
      repeat (gap) begin
        advance();
        rng_state     = xorshift(rng_state);
        instr_valid_i = 1'b0;
        instr_i       = rng_state;
      end
      advance();
      e       = stim_q[idx];
      e.entry = cycle;
      pend_q.push_back(e);
      instr_valid_i = 1'b1;
      instr_i       = e.instr;
    end
    advance();
    instr_valid_i = 1'b0;
    while (pend_q.size() > 0)
      advance();
    // catch a stray valid after the drain
    repeat (2) advance();
    finish_test();

    $display("done: %0d instructions, %0d checks, %0d errors", n_done, checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // worst case three cycles per instruction plus reset and drain
  initial begin
    wait (loaded);
    #((stim_q.size() * 4 + 20) * CLK_PERIOD);
    $display("timeout: run did not finish within %0d clock periods",
             stim_q.size() * 4 + 20);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/rv32_decode_pkg.sv
hw/instr_field_stage.sv
hw/exec_ctrl_stage.sv
hw/sys_ctrl_stage.sv
hw/rv32_decode_pipe.sv
test/tb_decode_pipe.sv
